// ==== Bender.yml ====
package:
  name: cacheSubsystem

sources:
  - design/cachePkg.sv
  - design/lineBusIf.sv
  - design/cacheCtrl.sv
  - design/cacheArray.sv
  - design/lineArbiter.sv
  - design/lineMemory.sv
  - design/cacheTop.sv
  - target: simulation
    files:
      - sim/cacheTb.sv

// ==== design/cacheArray.sv ====
// Two-way set associative tag, valid, dirty and line storage
// One LRU bit per set, victim selection and hit compare
// Flush set and way counters, line bus address and writeback data
`timescale 1ns/100ps
`default_nettype none

module cacheArray (
  input  wire                            clk,
  input  wire                            reset,
  input  wire  [cachePkg::adrBits-1:0]   adr,
  input  wire  [cachePkg::wordBits-1:0]  wdata,
  input  wire                            cacheWrite,
  output logic [cachePkg::wordBits-1:0]  rdata,
  // Controller
  input  wire                            selWriteback,
  input  wire                            setValid,
  input  wire                            setDirty,
  input  wire                            clearDirty,
  input  wire                            lruWriteEn,
  input  wire                            selFlush,
  input  wire                            flushAdrCntEn,
  input  wire                            flushWayCntEn,
  input  wire                            flushCntRst,
  output logic                           hit,
  output logic                           lineDirty,
  output logic                           flushAdrFlag,
  output logic                           flushWayFlag,
  lineBusIf.requester                    bus
);

  // Storage, indexed [way][set]
  logic [cachePkg::tagBits-1:0]        tags  [cachePkg::numWays][1 << cachePkg::setBits];
  logic [cachePkg::lineBits-1:0]       lines [cachePkg::numWays][1 << cachePkg::setBits];
  logic [(1 << cachePkg::setBits)-1:0] valid [cachePkg::numWays];
  logic [(1 << cachePkg::setBits)-1:0] dirty [cachePkg::numWays];
  logic [(1 << cachePkg::setBits)-1:0] lru;                 // Least recently used way

  logic [cachePkg::tagBits-1:0]    reqTag;
  logic [cachePkg::setBits-1:0]    reqSet;
  logic [cachePkg::offsetBits-1:0] reqOffset;
  logic [cachePkg::setBits-1:0]    set;
  logic [cachePkg::setBits-1:0]    flushSet;
  logic                            flushWay;
  logic [cachePkg::numWays-1:0]    wayHit;
  logic                            selWay;                  // Two ways, one bit
  logic [cachePkg::lineBits-1:0]   curLine;
  logic [cachePkg::lineBits-1:0]   fillLine;

  // Address slicing
  assign reqTag    = adr[cachePkg::adrBits-1 -: cachePkg::tagBits];
  assign reqSet    = adr[cachePkg::offsetBits +: cachePkg::setBits];
  assign reqOffset = adr[cachePkg::offsetBits-1:0];
  assign set       = selFlush ? flushSet : reqSet;

  always_comb begin
    for (int w = 0; w < cachePkg::numWays; w++)
      wayHit[w] = valid[w][reqSet] && (tags[w][reqSet] == reqTag);
  end

  assign hit = |wayHit;
  // Flush walks the counters, else the hit way, else the LRU victim
  assign selWay    = selFlush ? flushWay : (hit ? wayHit[1] : lru[set]);
  assign lineDirty = dirty[selWay][set];
  assign curLine   = lines[selWay][set];
  assign rdata     = curLine[reqOffset*cachePkg::wordBits +: cachePkg::wordBits];

  // Refill data with the store word merged in
  always_comb begin
    fillLine = bus.readLine;
    if (cacheWrite)
      fillLine[reqOffset*cachePkg::wordBits +: cachePkg::wordBits] = wdata;
  end

  // Writeback address comes from the stored tag
  assign bus.lineAdr   = (selFlush | selWriteback) ? {tags[selWay][set], set} : {reqTag, reqSet};
  assign bus.writeLine = curLine;

  assign flushAdrFlag = &flushSet;
  assign flushWayFlag = flushWay == 1'(cachePkg::numWays - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      tags     <= '{default: '0};
      lines    <= '{default: '0};
      valid    <= '{default: '0};
      dirty    <= '{default: '0};
      lru      <= '0;
      flushSet <= '0;
      flushWay <= 1'b0;
    end else begin
      if (setValid) begin
        tags[selWay][set]  <= reqTag;
        lines[selWay][set] <= fillLine;
        valid[selWay][set] <= 1'b1;
      end else if (cacheWrite && hit) begin
        lines[selWay][set][reqOffset*cachePkg::wordBits +: cachePkg::wordBits] <= wdata;
      end
      if (setDirty)        dirty[selWay][set] <= 1'b1;
      else if (clearDirty) dirty[selWay][set] <= 1'b0;
      if (lruWriteEn) lru[set] <= ~selWay;          // Other way becomes LRU
      // Flush counters, reset wins
      if (flushCntRst) begin
        flushSet <= '0;
        flushWay <= 1'b0;
      end else begin
        if (flushWayCntEn) flushWay <= flushWay + 1'b1;
        if (flushAdrCntEn) flushSet <= flushSet + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/cacheCtrl.sv ====
// Cache controller FSM
// Miss refill with dirty victim writeback, full flush of dirty lines
// Drives array write enables, flush counters and line bus requests
`timescale 1ns/100ps
`default_nettype none

module cacheCtrl #(
  parameter bit readOnly = 1'b0           // Instruction side, no write or flush paths
) (
  input  wire        clk,
  input  wire        reset,
  // Requester side
  input  wire        cacheRead,
  input  wire        cacheWrite,
  input  wire        flushReq,
  output logic       cacheStall,
  // From the array
  input  wire        hit,
  input  wire        lineDirty,           // Selected victim or flush line
  input  wire        flushAdrFlag,        // Last set
  input  wire        flushWayFlag,        // Last way
  // To the array
  output logic       selWriteback,
  output logic       setValid,
  output logic       setDirty,
  output logic       clearDirty,
  output logic       lruWriteEn,
  output logic       selFlush,
  output logic       flushAdrCntEn,
  output logic       flushWayCntEn,
  output logic       flushCntRst,
  lineBusIf.requester bus
);

  cachePkg::ctrlState state, nextState;

  logic anyMiss;
  logic anyHit;
  logic flushGo;
  logic flushFlag;
  logic flushDone;      // Final flush step completes this cycle

  assign anyMiss   = (cacheRead | cacheWrite) & ~hit;
  assign anyHit    = (cacheRead | cacheWrite) & hit;
  assign flushGo   = flushReq & ~readOnly;
  assign flushFlag = flushAdrFlag & flushWayFlag;

  always_ff @(posedge clk) begin
    if (reset) state <= cachePkg::stReady;
    else       state <= nextState;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nextState = state;
    case (state)
      cachePkg::stReady: begin
        if (flushGo)                               nextState = cachePkg::stFlush;
        else if (anyMiss && (readOnly || !lineDirty)) nextState = cachePkg::stFetch;
        else if (anyMiss)                          nextState = cachePkg::stWriteback; // Dirty victim
      end
      cachePkg::stFetch:
        if (bus.busAck) nextState = cachePkg::stWriteLine;
      cachePkg::stWriteLine:
        nextState = cachePkg::stReady;        // Lookup hits next cycle
      cachePkg::stWriteback:
        if (bus.busAck) nextState = cachePkg::stFetch;
      cachePkg::stFlush: begin
        if (lineDirty)      nextState = cachePkg::stFlushWriteback;
        else if (flushFlag) nextState = cachePkg::stReady;
      end
      cachePkg::stFlushWriteback: begin
        if (bus.busAck && !flushFlag) nextState = cachePkg::stFlush;
        else if (bus.busAck)          nextState = cachePkg::stReady;
      end
      default: nextState = cachePkg::stReady;
    endcase
  end

  // Last line of the flush visited and nothing left to write
  assign flushDone = (state == cachePkg::stFlush & flushFlag & ~lineDirty) |
                     (state == cachePkg::stFlushWriteback & flushFlag & bus.busAck);

  // Stall drops in the cycle the flush finishes, so the held flushReq is accepted
  assign cacheStall = (state == cachePkg::stReady & (anyMiss | flushGo)) |
                      (state == cachePkg::stFetch) |
                      (state == cachePkg::stWriteback) |
                      (state == cachePkg::stWriteLine) |
                      ((state == cachePkg::stFlush | state == cachePkg::stFlushWriteback) &
                       ~flushDone);

  ////////////////////////////////////////////////////////////////////////////
  // Array controls
  ////////////////////////////////////////////////////////////////////////////
  // Refill victim in the ack cycle, readLine is only valid then
  assign setValid   = (state == cachePkg::stFetch) & bus.busAck;
  assign lruWriteEn = (state == cachePkg::stReady & anyHit) |
                      (state == cachePkg::stWriteLine);
  assign setDirty   = (state == cachePkg::stReady & cacheWrite & hit) |
                      (state == cachePkg::stWriteLine & cacheWrite);  // Allocate then store
  assign clearDirty = (state == cachePkg::stWriteLine & ~cacheWrite) |
                      (state == cachePkg::stFlush & lineDirty);

  assign selWriteback = state == cachePkg::stWriteback;               // Victim tag on the bus
  assign selFlush     = (state == cachePkg::stFlush) |
                        (state == cachePkg::stFlushWriteback);

  // Way steps every line, set steps after the last way
  assign flushWayCntEn = (state == cachePkg::stFlush & ~lineDirty) |
                         (state == cachePkg::stFlushWriteback & bus.busAck);
  assign flushAdrCntEn = flushWayCntEn & flushWayFlag;
  assign flushCntRst   = flushDone;

  // Bus requests held through the ack cycle
  assign bus.busRead  = state == cachePkg::stFetch;
  assign bus.busWrite = (state == cachePkg::stWriteback) |
                        (state == cachePkg::stFlushWriteback);

endmodule

`default_nettype wire

// ==== design/cachePkg.sv ====
// Shared cache geometry and address slicing widths
// Backing memory size, latency and reset pattern key
// Controller state encoding
`default_nettype none

package cachePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////
  localparam int wordBits   = 32;                                 // Data word
  localparam int adrBits    = 8;                                  // Word address, 256 words
  localparam int offsetBits = 2;                                  // 4 words per line
  localparam int setBits    = 2;                                  // 4 sets
  localparam int tagBits    = adrBits - setBits - offsetBits;     // Remaining upper bits
  localparam int numWays    = 2;
  localparam int lineBits   = wordBits << offsetBits;             // 128 bit line

  // Backing line memory
  localparam int memLines   = 64;
  localparam int memLatency = 4;                                  // Request to ack, cycles
  localparam logic [31:0] memInitKey = 32'h5A3C_96E1;             // Word a resets to a ^ key

  // Miss, writeback and flush sequencing
  typedef enum logic [2:0] {
    stReady,
    stFetch,
    stWriteback,
    stWriteLine,
    stFlush,
    stFlushWriteback
  } ctrlState;

endpackage

`default_nettype wire

// ==== design/cacheTop.sv ====
// Cache subsystem top level
// Read-only instruction cache and write-back data cache
// Shared line memory behind a round-robin arbiter
`timescale 1ns/100ps
`default_nettype none

module cacheTop (
  input  wire                           clk,
  input  wire                           reset,
  // Instruction port
  input  wire                           fetchReq,
  input  wire  [cachePkg::adrBits-1:0]  fetchAdr,
  output logic [cachePkg::wordBits-1:0] fetchData,
  output logic                          fetchStall,
  // Data port
  input  wire                           dataRead,
  input  wire                           dataWrite,
  input  wire  [cachePkg::adrBits-1:0]  dataAdr,
  input  wire  [cachePkg::wordBits-1:0] dataWData,
  output logic [cachePkg::wordBits-1:0] dataRData,
  output logic                          dataStall,
  input  wire                           flushReq
);

  lineBusIf instBus ();
  lineBusIf dataBus ();
  lineBusIf memBus ();

  ////////////////////////////////////////////////////////////////////////////
  // Instruction side, write and flush tied off
  ////////////////////////////////////////////////////////////////////////////
  logic iHit, iDirty, iAdrFlag, iWayFlag;
  logic iSelWb, iSetValid, iSetDirty, iClrDirty, iLruEn;
  logic iSelFlush, iAdrCntEn, iWayCntEn, iCntRst;

  cacheCtrl #(.readOnly(1'b1)) u_instCtrl (
    .clk, .reset, .cacheRead(fetchReq), .cacheWrite(1'b0), .flushReq(1'b0),
    .cacheStall(fetchStall), .hit(iHit), .lineDirty(iDirty),
    .flushAdrFlag(iAdrFlag), .flushWayFlag(iWayFlag),
    .selWriteback(iSelWb), .setValid(iSetValid), .setDirty(iSetDirty),
    .clearDirty(iClrDirty), .lruWriteEn(iLruEn), .selFlush(iSelFlush),
    .flushAdrCntEn(iAdrCntEn), .flushWayCntEn(iWayCntEn), .flushCntRst(iCntRst),
    .bus(instBus.requester)
  );

  cacheArray u_instArray (
    .clk, .reset, .adr(fetchAdr), .wdata('0), .cacheWrite(1'b0), .rdata(fetchData),
    .selWriteback(iSelWb), .setValid(iSetValid), .setDirty(iSetDirty),
    .clearDirty(iClrDirty), .lruWriteEn(iLruEn), .selFlush(iSelFlush),
    .flushAdrCntEn(iAdrCntEn), .flushWayCntEn(iWayCntEn), .flushCntRst(iCntRst),
    .hit(iHit), .lineDirty(iDirty), .flushAdrFlag(iAdrFlag), .flushWayFlag(iWayFlag),
    .bus(instBus.requester)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data side
  ////////////////////////////////////////////////////////////////////////////
  logic dHit, dDirty, dAdrFlag, dWayFlag;
  logic dSelWb, dSetValid, dSetDirty, dClrDirty, dLruEn;
  logic dSelFlush, dAdrCntEn, dWayCntEn, dCntRst;

  cacheCtrl #(.readOnly(1'b0)) u_dataCtrl (
    .clk, .reset, .cacheRead(dataRead), .cacheWrite(dataWrite), .flushReq,
    .cacheStall(dataStall), .hit(dHit), .lineDirty(dDirty),
    .flushAdrFlag(dAdrFlag), .flushWayFlag(dWayFlag),
    .selWriteback(dSelWb), .setValid(dSetValid), .setDirty(dSetDirty),
    .clearDirty(dClrDirty), .lruWriteEn(dLruEn), .selFlush(dSelFlush),
    .flushAdrCntEn(dAdrCntEn), .flushWayCntEn(dWayCntEn), .flushCntRst(dCntRst),
    .bus(dataBus.requester)
  );

  cacheArray u_dataArray (
    .clk, .reset, .adr(dataAdr), .wdata(dataWData), .cacheWrite(dataWrite),
    .rdata(dataRData),
    .selWriteback(dSelWb), .setValid(dSetValid), .setDirty(dSetDirty),
    .clearDirty(dClrDirty), .lruWriteEn(dLruEn), .selFlush(dSelFlush),
    .flushAdrCntEn(dAdrCntEn), .flushWayCntEn(dWayCntEn), .flushCntRst(dCntRst),
    .hit(dHit), .lineDirty(dDirty), .flushAdrFlag(dAdrFlag), .flushWayFlag(dWayFlag),
    .bus(dataBus.requester)
  );

  // Shared backing store
  lineArbiter u_arbiter (
    .clk, .reset,
    .instPort(instBus.responder), .dataPort(dataBus.responder), .memPort(memBus.requester)
  );

  lineMemory u_memory (.clk, .reset, .memPort(memBus.responder));

endmodule

`default_nettype wire

// ==== design/lineArbiter.sv ====
// Round-robin arbiter for the line memory
// Grant held from first request until busAck, priority alternates on ties
`timescale 1ns/100ps
`default_nettype none

module lineArbiter (
  input  wire          clk,
  input  wire          reset,
  lineBusIf.responder  instPort,
  lineBusIf.responder  dataPort,
  lineBusIf.requester  memPort
);

  logic [1:0] owner;      // One-hot, bit 1 data side, zero when idle
  logic       prioData;   // Data side wins the next tie
  logic [1:0] grant;
  logic       instReq;
  logic       dataReq;

  assign instReq = instPort.busRead | instPort.busWrite;
  assign dataReq = dataPort.busRead | dataPort.busWrite;

  // Combinational from owner, so no added cycle
  always_comb begin
    if (owner != 2'b00)         grant = owner;
    else if (instReq && dataReq) grant = prioData ? 2'b10 : 2'b01;
    else                        grant = {dataReq, instReq};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      owner    <= 2'b00;
      prioData <= 1'b0;
    end else if (memPort.busAck) begin
      owner    <= 2'b00;
      prioData <= grant[0];                 // Other side next
    end else if (owner == 2'b00) begin
      owner    <= grant;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Forward granted request, ack only its owner
  ////////////////////////////////////////////////////////////////////////////
  assign memPort.busRead   = grant[1] ? dataPort.busRead  : (grant[0] & instPort.busRead);
  assign memPort.busWrite  = grant[1] ? dataPort.busWrite : (grant[0] & instPort.busWrite);
  assign memPort.lineAdr   = grant[1] ? dataPort.lineAdr   : instPort.lineAdr;
  assign memPort.writeLine = grant[1] ? dataPort.writeLine : instPort.writeLine;

  assign instPort.readLine = memPort.readLine;
  assign dataPort.readLine = memPort.readLine;
  assign instPort.busAck   = memPort.busAck & grant[0];
  assign dataPort.busAck   = memPort.busAck & grant[1];

endmodule

`default_nettype wire

// ==== design/lineBusIf.sv ====
// Line transfer bus between a cache and the arbiter, or arbiter and memory
// Request held until a one-cycle acknowledge
`timescale 1ns/100ps
`default_nettype none

interface lineBusIf;

  logic                                            busRead;   // Line fetch
  logic                                            busWrite;  // Line writeback
  logic [cachePkg::adrBits-cachePkg::offsetBits-1:0] lineAdr;
  logic [cachePkg::lineBits-1:0]                   writeLine;
  logic [cachePkg::lineBits-1:0]                   readLine;  // Valid with busAck
  logic                                            busAck;    // Single-cycle pulse

  // Cache side or arbiter toward memory
  modport requester (
    output busRead, busWrite, lineAdr, writeLine,
    input  readLine, busAck
  );

  // Arbiter toward caches or the memory itself
  modport responder (
    input  busRead, busWrite, lineAdr, writeLine,
    output readLine, busAck
  );

endinterface

`default_nettype wire

// ==== design/lineMemory.sv ====
// Backing line memory with fixed access latency
// Reset content follows the address XOR key pattern
`timescale 1ns/100ps
`default_nettype none

module lineMemory (
  input  wire          clk,
  input  wire          reset,
  lineBusIf.responder  memPort
);

  logic [cachePkg::lineBits-1:0]            mem [cachePkg::memLines];
  logic [$clog2(cachePkg::memLatency+1)-1:0] latCnt;   // Zero when idle
  logic                                     busReq;

  assign busReq = memPort.busRead | memPort.busWrite;

  // Ack at the end of the count, access happens in that cycle
  assign memPort.busAck   = latCnt == cachePkg::memLatency;
  assign memPort.readLine = mem[memPort.lineAdr];

  always_ff @(posedge clk) begin
    if (reset) begin
      latCnt <= '0;
      for (int l = 0; l < cachePkg::memLines; l++) begin
        for (int w = 0; w < (1 << cachePkg::offsetBits); w++) begin
          mem[l][w*cachePkg::wordBits +: cachePkg::wordBits] <=
            32'((l << cachePkg::offsetBits) + w) ^ cachePkg::memInitKey;
        end
      end
    end else begin
      if (memPort.busAck)
        latCnt <= '0;
      else if (latCnt != 0 || busReq)
        latCnt <= latCnt + 1'b1;              // Starts on first sight of a request
      if (memPort.busAck && memPort.busWrite)
        mem[memPort.lineAdr] <= memPort.writeLine;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/cachePkg.sv
design/lineBusIf.sv
design/cacheCtrl.sv
design/cacheArray.sv
design/lineArbiter.sv
design/lineMemory.sv
design/cacheTop.sv
sim/cacheTb.sv

// ==== sim/cacheTb.sv ====
// Testbench for the two-port cache subsystem
// Stimulus table applied in a loop, reference word memory and flushed image
// Clock, reset, watchdog and value check task
`timescale 1ns/100ps
`default_nettype none

module cacheTb;

  typedef enum logic [1:0] {portInst, portData, portBoth} portKind;
  typedef enum logic [1:0] {opRead, opWrite, opFlush} opKind;

  typedef struct packed {
    portKind                      port;
    opKind                        op;
    logic [cachePkg::adrBits-1:0] adr;
    logic [cachePkg::wordBits-1:0] data;    // Store word, random
    logic                         expHit;   // Stall must be low in the request cycle
  } stimEntry;

  localparam int numWords    = 1 << cachePkg::adrBits;
  localparam int resetCycles = 3;

  logic                          clk;
  logic                          reset;
  logic                          fetchReq;
  logic [cachePkg::adrBits-1:0]  fetchAdr;
  logic [cachePkg::wordBits-1:0] fetchData;
  logic                          fetchStall;
  logic                          dataRead;
  logic                          dataWrite;
  logic [cachePkg::adrBits-1:0]  dataAdr;
  logic [cachePkg::wordBits-1:0] dataWData;
  logic [cachePkg::wordBits-1:0] dataRData;
  logic                          dataStall;
  logic                          flushReq;

  logic [cachePkg::wordBits-1:0] refMem     [numWords];  // Current data view
  logic [cachePkg::wordBits-1:0] flushedMem [numWords];  // Memory as of the last flush
  stimEntry                      stimTable  [$];
  int                            errorCount = 0;

  cacheTop u_dut (
    .clk, .reset,
    .fetchReq, .fetchAdr, .fetchData, .fetchStall,
    .dataRead, .dataWrite, .dataAdr, .dataWData, .dataRData, .dataStall, .flushReq
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                 // 10 ns period
  end

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic addEntry(input portKind port, input opKind op,
                          input logic [cachePkg::adrBits-1:0] adr, input logic expHit);
    stimEntry e;
    e.port   = port;
    e.op     = op;
    e.adr    = adr;
    e.data   = (op == opWrite) ? $urandom() : '0;
    e.expHit = expHit;
    stimTable.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table, address is tag[7:4] set[3:2] offset[1:0]
  ////////////////////////////////////////////////////////////////////////////
  task automatic buildTable();
    // Cold reads over all sets, then a repeat hit
    addEntry(portData, opRead, 8'h00, 1'b0);
    addEntry(portData, opRead, 8'h05, 1'b0);
    addEntry(portData, opRead, 8'h0A, 1'b0);
    addEntry(portData, opRead, 8'h0F, 1'b0);
    addEntry(portData, opRead, 8'h00, 1'b1);
    // Store hit, read back, neighbour untouched
    addEntry(portData, opWrite, 8'h05, 1'b1);
    addEntry(portData, opRead, 8'h05, 1'b1);
    addEntry(portData, opRead, 8'h06, 1'b1);
    // Set 2 thrash, dirty 0x18 line evicted then refetched
    addEntry(portData, opWrite, 8'h18, 1'b0);
    addEntry(portData, opRead, 8'h28, 1'b0);
    addEntry(portData, opRead, 8'h38, 1'b0);
    addEntry(portData, opRead, 8'h18, 1'b0);
    // Fetch sees memory, not the dirty data line
    addEntry(portInst, opRead, 8'h05, 1'b0);
    addEntry(portInst, opRead, 8'h06, 1'b1);
    // Stores, flush, then fetches of fresh instruction lines
    addEntry(portData, opWrite, 8'h41, 1'b0);
    addEntry(portData, opWrite, 8'h0D, 1'b1);
    addEntry(portData, opFlush, 8'h00, 1'b0);
    addEntry(portInst, opRead, 8'h41, 1'b0);
    addEntry(portInst, opRead, 8'h0D, 1'b0);
    addEntry(portInst, opRead, 8'h19, 1'b0);
    addEntry(portInst, opRead, 8'h18, 1'b1);
    addEntry(portData, opRead, 8'h05, 1'b1);  // Still valid after flush
    // Both sides miss at once, arbiter contention
    addEntry(portBoth, opRead, 8'h90, 1'b0);
    addEntry(portBoth, opRead, 8'hA3, 1'b0);
  endtask

  task automatic idleInputs();
    fetchReq  = 1'b0;
    fetchAdr  = '0;
    dataRead  = 1'b0;
    dataWrite = 1'b0;
    dataAdr   = '0;
    dataWData = '0;
    flushReq  = 1'b0;
  endtask

  task automatic driveEntry(input stimEntry e);
    idleInputs();
    if (e.port != portData) begin
      fetchReq = 1'b1;
      fetchAdr = e.adr;
    end
    if (e.port != portInst) begin
      dataRead  = e.op == opRead;
      dataWrite = e.op == opWrite;
      flushReq  = e.op == opFlush;
      dataAdr   = e.adr;
      dataWData = e.data;
    end
  endtask

  // Drive one entry, wait for the stall to clear at an edge, then check
  task automatic runEntry(input int idx);
    stimEntry                      e;
    logic                          stalled;
    int                            cycles;
    string                         stallName;
    logic [cachePkg::wordBits-1:0] gotInst;
    logic [cachePkg::wordBits-1:0] gotData;
    e         = stimTable[idx];
    stallName = (e.port == portInst) ? "fetchStall" : "dataStall";
    cycles    = 0;
    driveEntry(e);
    do begin
      @(negedge clk);                          // Outputs settled mid-cycle
      stalled = ((e.port != portData) & fetchStall) | ((e.port != portInst) & dataStall);
      if (cycles == 0 && e.expHit)
        checkValue($sformatf("%s[%0d]", stallName, idx), stalled, 0);
      gotInst = fetchData;
      gotData = dataRData;
      cycles++;
      @(posedge clk);                          // Accepted here when stall is low
    end while (stalled);
    #1;
    idleInputs();
    case (e.op)
      opRead: begin
        if (e.port != portData)
          checkValue($sformatf("fetchData[%0d]", idx), gotInst, flushedMem[e.adr]);
        if (e.port != portInst)
          checkValue($sformatf("dataRData[%0d]", idx), gotData, refMem[e.adr]);
      end
      opWrite: refMem[e.adr] = e.data;
      default: flushedMem = refMem;            // Every dirty line now in memory
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(87704));
    reset = 1'b1;
    idleInputs();
    for (int a = 0; a < numWords; a++)
      refMem[a] = 32'(a) ^ cachePkg::memInitKey;   // Memory reset rule
    flushedMem = refMem;
    buildTable();
    repeat (resetCycles) @(posedge clk);
    #1 reset = 1'b0;
    // Idle state after reset
    @(negedge clk);
    checkValue("fetchStall", fetchStall, 0);
    checkValue("dataStall", dataStall, 0);
    checkValue("memBus.busRead", u_dut.memBus.busRead, 0);
    checkValue("memBus.busWrite", u_dut.memBus.busWrite, 0);
    @(posedge clk);
    #1;
    for (int i = 0; i < stimTable.size(); i++)
      runEntry(i);
    $display("Errors: %0d", errorCount);
    if (errorCount == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Watchdog, 80 cycles per table entry
  initial begin
    #1;
    repeat (stimTable.size() * 80 + resetCycles) @(posedge clk);
    $display("Timeout: stall never cleared within the allowed number of cycles");
    $display("Errors: %0d", errorCount);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
